// ==== ep_pkg.sv ====
// Packet, register-map and status types shared by the endpoint RTL and its testbench
package ep_pkg;

    localparam int DATA_W = 64;    // Stream beat width

    typedef enum logic [1:0] {
        KIND_REG_WR = 2'd0,
        KIND_REG_RD = 2'd1,
        KIND_CPLD   = 2'd2,
        KIND_DMA_WR = 2'd3
    } ep_kind_e;

    // Sits in beat bits 63:32
    typedef struct packed {
        ep_kind_e   kind;
        logic [7:0] tag;
        logic [9:0] len;         // Payload beats
        logic [3:0] reg_addr;
        logic [7:0] addr_hi;
    } ep_hdr_t;

    typedef enum logic [3:0] {
        REG_CTRL      = 4'd0,
        REG_ADDR_LO   = 4'd1,
        REG_ADDR_HI   = 4'd2,
        REG_FRAME_LEN = 4'd3,
        REG_BPMID     = 4'd4,
        REG_TF_LEN    = 4'd5,
        REG_STATUS    = 4'd6,
        REG_LINK      = 4'd7
    } ep_reg_e;

    typedef struct packed {
        logic        en;
        ep_reg_e     addr;
        logic [31:0] data;
    } reg_wr_t;

    typedef struct packed {
        logic [7:0] tag;
        ep_reg_e    reg_addr;
    } cpl_req_t;

    typedef struct packed {
        logic        enable;
        logic        restart;    // One-cycle pulse
        logic [39:0] base_addr;
        logic [9:0]  frame_len;
    } wdma_cfg_t;

    typedef struct packed {
        logic [15:0] frame_cnt;
        logic        overrun;
        logic        busy;
    } wdma_stat_t;

    typedef struct packed {
        logic [39:0] addr;
        logic [9:0]  len;
    } wdma_cmd_t;

endpackage

// ==== ep_reg_file.sv ====
// Control and status register file, with a combinational read port for completions
`timescale 1ns/1ps

module ep_reg_file (
    input  logic                clk,
    input  logic                rst_n,
    input  ep_pkg::reg_wr_t     reg_wr_i,
    input  ep_pkg::ep_reg_e     rd_addr_i,
    output logic [31:0]         rd_data_o,
    output ep_pkg::wdma_cfg_t   wdma_cfg_o,
    input  ep_pkg::wdma_stat_t  wdma_stat_i,
    input  logic                fofb_rxlink_up_i,
    input  logic [9:0]          fofb_rxlink_partner_i,
    output logic [9:0]          bpmid_o,
    output logic [15:0]         timeframe_length_o
);
    import ep_pkg::*;

    logic        dma_en;
    logic        restart;
    logic [31:0] addr_lo;
    logic [7:0]  addr_hi;
    logic [9:0]  frame_len;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dma_en             <= 1'b0;
            restart            <= 1'b0;
            addr_lo            <= '0;
            addr_hi            <= '0;
            frame_len          <= '0;
            bpmid_o            <= '0;
            timeframe_length_o <= '0;
        end else begin
            restart <= 1'b0;
            if (reg_wr_i.en) begin
                case (reg_wr_i.addr)
                    REG_CTRL: begin
                        dma_en  <= reg_wr_i.data[0];
                        restart <= reg_wr_i.data[0];    // Enable write also rewinds
                    end
                    REG_ADDR_LO:   addr_lo            <= reg_wr_i.data;
                    REG_ADDR_HI:   addr_hi            <= reg_wr_i.data[7:0];
                    REG_FRAME_LEN: frame_len          <= reg_wr_i.data[9:0];
                    REG_BPMID:     bpmid_o            <= reg_wr_i.data[9:0];
                    REG_TF_LEN:    timeframe_length_o <= reg_wr_i.data[15:0];
                    default: ;                          // Status, link, unmapped
                endcase
            end
        end
    end

    always_comb begin
        case (rd_addr_i)
            REG_CTRL:      rd_data_o = {31'd0, dma_en};
            REG_ADDR_LO:   rd_data_o = addr_lo;
            REG_ADDR_HI:   rd_data_o = {24'd0, addr_hi};
            REG_FRAME_LEN: rd_data_o = {22'd0, frame_len};
            REG_BPMID:     rd_data_o = {22'd0, bpmid_o};
            REG_TF_LEN:    rd_data_o = {16'd0, timeframe_length_o};
            REG_STATUS:    rd_data_o = {14'd0, wdma_stat_i.busy, wdma_stat_i.overrun,
                                        wdma_stat_i.frame_cnt};
            REG_LINK:      rd_data_o = {21'd0, fofb_rxlink_up_i, fofb_rxlink_partner_i};
            default:       rd_data_o = '0;
        endcase
    end

    assign wdma_cfg_o.enable    = dma_en;
    assign wdma_cfg_o.restart   = restart;
    assign wdma_cfg_o.base_addr = {addr_hi, addr_lo};
    assign wdma_cfg_o.frame_len = frame_len;

endmodule

// ==== ep_rx_engine.sv ====
// Receive engine: turns single-beat host requests into register writes and completion requests
`timescale 1ns/1ps

module ep_rx_engine (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [ep_pkg::DATA_W-1:0] rx_data_i,
    input  logic                      rx_sof_i,
    input  logic                      rx_eof_i,
    input  logic                      rx_valid_i,
    output logic                      rx_ready_o,
    output ep_pkg::reg_wr_t           reg_wr_o,
    output ep_pkg::cpl_req_t          cpl_req_o,
    output logic                      req_compl_o,
    input  logic                      compl_done_i
);
    import ep_pkg::*;

    ep_hdr_t hdr;
    logic    req_acc;

    assign hdr     = rx_data_i[DATA_W-1:32];
    assign req_acc = rx_valid_i && rx_ready_o && rx_sof_i && rx_eof_i;  // Multi-beat dropped

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_ready_o  <= 1'b1;
            req_compl_o <= 1'b0;
            reg_wr_o    <= '0;
            cpl_req_o   <= '0;
        end else begin
            reg_wr_o.en <= 1'b0;
            if (req_acc && hdr.kind == KIND_REG_WR) begin
                reg_wr_o.en   <= 1'b1;
                reg_wr_o.addr <= ep_reg_e'(hdr.reg_addr);
                reg_wr_o.data <= rx_data_i[31:0];
            end
            if (req_acc && hdr.kind == KIND_REG_RD) begin
                cpl_req_o.tag      <= hdr.tag;
                cpl_req_o.reg_addr <= ep_reg_e'(hdr.reg_addr);
                req_compl_o        <= 1'b1;
                rx_ready_o         <= 1'b0;     // Hold off until completion sent
            end
            if (compl_done_i) begin
                req_compl_o <= 1'b0;
                rx_ready_o  <= 1'b1;
            end
        end
    end

endmodule

// ==== ep_top.sv ====
// Endpoint top level: connects the receive, register, write-DMA and transmit engines
`timescale 1ns/1ps

module ep_top #(
    parameter int XY_ADDR_W = 10
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [ep_pkg::DATA_W-1:0] rx_data_i,
    input  logic                      rx_sof_i,
    input  logic                      rx_eof_i,
    input  logic                      rx_valid_i,
    output logic                      rx_ready_o,
    output logic [ep_pkg::DATA_W-1:0] tx_data_o,
    output logic                      tx_sof_o,
    output logic                      tx_eof_o,
    output logic                      tx_valid_o,
    input  logic                      tx_ready_i,
    output logic [XY_ADDR_W-1:0]      xy_buf_addr_o,
    input  logic [ep_pkg::DATA_W-1:0] xy_buf_dat_i,
    input  logic                      fofb_rxlink_up_i,
    input  logic [9:0]                fofb_rxlink_partner_i,
    input  logic                      timeframe_end_rise_i,
    output logic [9:0]                bpmid_o,
    output logic [15:0]               timeframe_length_o
);
    import ep_pkg::*;

    reg_wr_t     reg_wr;
    cpl_req_t    cpl_req;
    logic        req_compl;
    logic        compl_done;
    ep_reg_e     rd_addr;
    logic [31:0] rd_data;
    wdma_cfg_t   wdma_cfg;
    wdma_stat_t  wdma_stat;
    logic        wdma_start;
    wdma_cmd_t   wdma_cmd;
    logic        wdma_done;

    ep_rx_engine rx_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx_data_i    (rx_data_i),
        .rx_sof_i     (rx_sof_i),
        .rx_eof_i     (rx_eof_i),
        .rx_valid_i   (rx_valid_i),
        .rx_ready_o   (rx_ready_o),
        .reg_wr_o     (reg_wr),
        .cpl_req_o    (cpl_req),
        .req_compl_o  (req_compl),
        .compl_done_i (compl_done)
    );

    ep_reg_file regs_i (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .reg_wr_i              (reg_wr),
        .rd_addr_i             (rd_addr),
        .rd_data_o             (rd_data),
        .wdma_cfg_o            (wdma_cfg),
        .wdma_stat_i           (wdma_stat),
        .fofb_rxlink_up_i      (fofb_rxlink_up_i),
        .fofb_rxlink_partner_i (fofb_rxlink_partner_i),
        .bpmid_o               (bpmid_o),
        .timeframe_length_o    (timeframe_length_o)
    );

    ep_wdma_fsm wdma_i (
        .clk                  (clk),
        .rst_n                (rst_n),
        .wdma_cfg_i           (wdma_cfg),
        .timeframe_end_rise_i (timeframe_end_rise_i),
        .wdma_start_o         (wdma_start),
        .wdma_cmd_o           (wdma_cmd),
        .wdma_done_i          (wdma_done),
        .wdma_stat_o          (wdma_stat)
    );

    ep_tx_engine #(
        .XY_ADDR_W (XY_ADDR_W)
    ) tx_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .tx_data_o     (tx_data_o),
        .tx_sof_o      (tx_sof_o),
        .tx_eof_o      (tx_eof_o),
        .tx_valid_o    (tx_valid_o),
        .tx_ready_i    (tx_ready_i),
        .req_compl_i   (req_compl),
        .cpl_req_i     (cpl_req),
        .compl_done_o  (compl_done),
        .rd_addr_o     (rd_addr),
        .rd_data_i     (rd_data),
        .wdma_start_i  (wdma_start),
        .wdma_cmd_i    (wdma_cmd),
        .wdma_done_o   (wdma_done),
        .xy_buf_addr_o (xy_buf_addr_o),
        .xy_buf_dat_i  (xy_buf_dat_i)
    );

endmodule

// ==== ep_top_sva.sv ====
// Transmit-stream and XY-buffer assertions, bound into the endpoint top level
`timescale 1ns/1ps

module ep_top_sva #(
    parameter int XY_ADDR_W = 10
) (
    input logic                      clk,
    input logic                      rst_n,
    input logic [ep_pkg::DATA_W-1:0] tx_data_i,
    input logic                      tx_sof_i,
    input logic                      tx_eof_i,
    input logic                      tx_valid_i,
    input logic                      tx_ready_i,
    input logic [XY_ADDR_W-1:0]      xy_addr_i,
    input logic [9:0]                frame_len_i
);

    int fail_cnt = 0;    // Failed assertions so far

    quiet_in_reset: assert property (@(posedge clk) !rst_n |=> !tx_valid_i)
        else begin
            $error("tx_valid_o high after a reset cycle");
            fail_cnt++;
        end

    // Held beat must not move until the sink takes it
    beat_stable: assert property (@(posedge clk) disable iff (!rst_n)
        tx_valid_i && !tx_ready_i |=> tx_valid_i && $stable({tx_data_i, tx_sof_i, tx_eof_i}))
        else begin
            $error("transmit beat changed under back-pressure");
            fail_cnt++;
        end

    xy_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
        frame_len_i != 10'd0 |-> xy_addr_i < frame_len_i)
        else begin
            $error("xy_buf_addr_o beyond the frame length");
            fail_cnt++;
        end

endmodule

bind ep_top ep_top_sva #(
    .XY_ADDR_W (XY_ADDR_W)
) sva_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .tx_data_i   (tx_data_o),
    .tx_sof_i    (tx_sof_o),
    .tx_eof_i    (tx_eof_o),
    .tx_valid_i  (tx_valid_o),
    .tx_ready_i  (tx_ready_i),
    .xy_addr_i   (xy_buf_addr_o),
    .frame_len_i (wdma_cfg.frame_len)
);

// ==== ep_tx_engine.sv ====
// Transmit engine: builds completion and DMA write packets and holds beats under back-pressure
`timescale 1ns/1ps

module ep_tx_engine #(
    parameter int XY_ADDR_W = 10
) (
    input  logic                      clk,
    input  logic                      rst_n,
    output logic [ep_pkg::DATA_W-1:0] tx_data_o,
    output logic                      tx_sof_o,
    output logic                      tx_eof_o,
    output logic                      tx_valid_o,
    input  logic                      tx_ready_i,
    input  logic                      req_compl_i,
    input  ep_pkg::cpl_req_t          cpl_req_i,
    output logic                      compl_done_o,
    output ep_pkg::ep_reg_e           rd_addr_o,
    input  logic [31:0]               rd_data_i,
    input  logic                      wdma_start_i,
    input  ep_pkg::wdma_cmd_t         wdma_cmd_i,
    output logic                      wdma_done_o,
    output logic [XY_ADDR_W-1:0]      xy_buf_addr_o,
    input  logic [ep_pkg::DATA_W-1:0] xy_buf_dat_i
);
    import ep_pkg::*;

    // State names the beat held in the output register
    typedef enum logic [1:0] {ST_IDLE, ST_CPL, ST_DMA_HDR, ST_DMA_DATA} state_e;

    state_e    state;
    logic      dma_pend;
    wdma_cmd_t dma_cmd;
    ep_hdr_t   cpl_hdr;
    ep_hdr_t   dma_hdr;
    logic      in_dma;
    logic      last_beat;

    assign rd_addr_o    = cpl_req_i.reg_addr;
    assign in_dma       = state == ST_DMA_HDR || state == ST_DMA_DATA;
    assign compl_done_o = tx_valid_o && tx_ready_i && state == ST_CPL;
    assign wdma_done_o  = tx_valid_o && tx_ready_i && tx_eof_o && in_dma;
    assign last_beat    = xy_buf_addr_o == XY_ADDR_W'(dma_cmd.len - 10'd1);

    always_comb begin
        cpl_hdr          = '0;
        cpl_hdr.kind     = KIND_CPLD;
        cpl_hdr.tag      = cpl_req_i.tag;
        cpl_hdr.len      = 10'd1;
        cpl_hdr.reg_addr = cpl_req_i.reg_addr;
        dma_hdr          = '0;
        dma_hdr.kind     = KIND_DMA_WR;
        dma_hdr.len      = dma_cmd.len;
        dma_hdr.addr_hi  = dma_cmd.addr[39:32];
    end

    always_ff @(posedge clk) begin
        if (wdma_start_i) dma_cmd <= wdma_cmd_i;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            dma_pend      <= 1'b0;
            tx_valid_o    <= 1'b0;
            tx_sof_o      <= 1'b0;
            tx_eof_o      <= 1'b0;
            xy_buf_addr_o <= '0;
        end else begin
            if (wdma_start_i) dma_pend <= 1'b1;
            case (state)
                ST_IDLE: begin
                    if (req_compl_i) begin                  // Completions win
                        tx_data_o  <= {cpl_hdr, rd_data_i};
                        tx_sof_o   <= 1'b1;
                        tx_eof_o   <= 1'b1;
                        tx_valid_o <= 1'b1;
                        state      <= ST_CPL;
                    end else if (dma_pend) begin
                        tx_data_o  <= {dma_hdr, dma_cmd.addr[31:0]};
                        tx_sof_o   <= 1'b1;
                        tx_eof_o   <= dma_cmd.len == 10'd0;
                        tx_valid_o <= 1'b1;
                        dma_pend   <= 1'b0;
                        state      <= ST_DMA_HDR;
                    end
                end
                ST_CPL: begin
                    if (tx_ready_i) begin
                        tx_valid_o <= 1'b0;
                        state      <= ST_IDLE;
                    end
                end
                ST_DMA_HDR, ST_DMA_DATA: begin
                    if (tx_ready_i && tx_eof_o) begin
                        tx_valid_o <= 1'b0;
                        state      <= ST_IDLE;
                    end else if (tx_ready_i) begin
                        tx_data_o     <= xy_buf_dat_i;      // Word at xy_buf_addr_o
                        tx_sof_o      <= 1'b0;
                        tx_eof_o      <= last_beat;
                        xy_buf_addr_o <= last_beat ? '0 : xy_buf_addr_o + 1'b1;
                        state         <= ST_DMA_DATA;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== ep_wdma_fsm.sv ====
// Write-DMA sequencer: launches one frame per timeframe end and tracks frame address and count
`timescale 1ns/1ps

module ep_wdma_fsm (
    input  logic                clk,
    input  logic                rst_n,
    input  ep_pkg::wdma_cfg_t   wdma_cfg_i,
    input  logic                timeframe_end_rise_i,
    output logic                wdma_start_o,
    output ep_pkg::wdma_cmd_t   wdma_cmd_o,
    input  logic                wdma_done_i,
    output ep_pkg::wdma_stat_t  wdma_stat_o
);
    import ep_pkg::*;

    typedef enum logic {ST_IDLE, ST_BUSY} state_e;

    state_e      state;
    logic [39:0] frame_ofs;     // Offset of next frame from base
    logic [15:0] frame_cnt;
    logic        overrun;
    logic        launch;

    assign launch = state == ST_IDLE && timeframe_end_rise_i && wdma_cfg_i.enable;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            wdma_start_o <= 1'b0;
            frame_ofs    <= '0;
            frame_cnt    <= '0;
            overrun      <= 1'b0;
        end else begin
            wdma_start_o <= launch;
            case (state)
                ST_IDLE: if (launch) state <= ST_BUSY;
                ST_BUSY: begin
                    if (timeframe_end_rise_i) overrun <= 1'b1;   // Sticky
                    if (wdma_done_i) begin
                        state     <= ST_IDLE;
                        frame_cnt <= frame_cnt + 16'd1;
                        frame_ofs <= frame_ofs + {27'd0, wdma_cmd_o.len, 3'd0};
                    end
                end
                default: state <= ST_IDLE;
            endcase
            if (wdma_cfg_i.restart) begin
                frame_ofs <= '0;
                frame_cnt <= '0;
                overrun   <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            wdma_cmd_o.addr <= wdma_cfg_i.restart ? wdma_cfg_i.base_addr
                                                  : wdma_cfg_i.base_addr + frame_ofs;
            wdma_cmd_o.len  <= wdma_cfg_i.frame_len;
        end
    end

    assign wdma_stat_o.frame_cnt = frame_cnt;
    assign wdma_stat_o.overrun   = overrun;
    assign wdma_stat_o.busy      = state == ST_BUSY;

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_ep_top -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "All tests passed!" \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }

// ==== tb_ep_top.sv ====
// Table-driven testbench for the endpoint: register access, completions and DMA frames
`timescale 1ns/1ps

module tb_ep_top;
    import ep_pkg::*;

    localparam int XY_ADDR_W = 10;

    typedef enum logic [1:0] {OP_WR, OP_RD, OP_TRIG, OP_LINK} op_e;

    typedef struct packed {
        op_e         op;
        ep_reg_e     addr;
        logic [31:0] data;    // Write data, link value or trigger pulses
        logic [31:0] exp;     // Read value or payload beats
    } step_t;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic [DATA_W-1:0]    rx_data_i;
    logic                 rx_sof_i;
    logic                 rx_eof_i;
    logic                 rx_valid_i;
    logic                 rx_ready_o;
    logic [DATA_W-1:0]    tx_data_o;
    logic                 tx_sof_o;
    logic                 tx_eof_o;
    logic                 tx_valid_o;
    logic                 tx_ready_i = 1'b1;
    logic [XY_ADDR_W-1:0] xy_buf_addr_o;
    logic [DATA_W-1:0]    xy_buf_dat_i;
    logic                 fofb_rxlink_up_i;
    logic [9:0]           fofb_rxlink_partner_i;
    logic                 timeframe_end_rise_i;
    logic [9:0]           bpmid_o;
    logic [15:0]          timeframe_length_o;

    logic [DATA_W-1:0] xy_mem [2**XY_ADDR_W];
    step_t             steps[$];
    string             names[$];
    logic [65:0]       beats_q[$];    // {sof, eof, data}
    int                cycles;
    int                limit;
    int                n_pass;
    int                n_fail;
    int                test_errs;
    logic [39:0]       base;
    int                frame_n;
    logic [7:0]        tag;

    ep_top #(
        .XY_ADDR_W (XY_ADDR_W)
    ) ep_top_i (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .rx_data_i             (rx_data_i),
        .rx_sof_i              (rx_sof_i),
        .rx_eof_i              (rx_eof_i),
        .rx_valid_i            (rx_valid_i),
        .rx_ready_o            (rx_ready_o),
        .tx_data_o             (tx_data_o),
        .tx_sof_o              (tx_sof_o),
        .tx_eof_o              (tx_eof_o),
        .tx_valid_o            (tx_valid_o),
        .tx_ready_i            (tx_ready_i),
        .xy_buf_addr_o         (xy_buf_addr_o),
        .xy_buf_dat_i          (xy_buf_dat_i),
        .fofb_rxlink_up_i      (fofb_rxlink_up_i),
        .fofb_rxlink_partner_i (fofb_rxlink_partner_i),
        .timeframe_end_rise_i  (timeframe_end_rise_i),
        .bpmid_o               (bpmid_o),
        .timeframe_length_o    (timeframe_length_o)
    );

    assign xy_buf_dat_i = xy_mem[xy_buf_addr_o];    // Combinational buffer read

    always #10 clk = ~clk;

    always @(negedge clk) tx_ready_i = ($urandom % 4) != 0;    // Random back-pressure

    always @(posedge clk) begin
        if (rst_n && tx_valid_o && tx_ready_i) beats_q.push_back({tx_sof_o, tx_eof_o, tx_data_o});
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic add_step(input string name, input op_e op, input ep_reg_e addr,
                            input logic [31:0] data, input logic [31:0] exp);
        step_t s;
        s.op   = op;
        s.addr = addr;
        s.data = data;
        s.exp  = exp;
        steps.push_back(s);
        names.push_back(name);
    endtask

    task automatic send_req(input ep_kind_e kind, input ep_reg_e addr, input logic [31:0] data);
        ep_hdr_t h;
        h          = '0;
        h.kind     = kind;
        h.tag      = tag;
        h.len      = 10'd1;
        h.reg_addr = addr;
        while (!rx_ready_o) @(negedge clk);
        rx_data_i  = {h, data};
        rx_sof_i   = 1'b1;
        rx_eof_i   = 1'b1;
        rx_valid_i = 1'b1;
        @(negedge clk);
        rx_valid_i = 1'b0;
        rx_sof_i   = 1'b0;
        rx_eof_i   = 1'b0;
    endtask

    task automatic write_reg(input string name, input ep_reg_e addr, input logic [31:0] data);
        send_req(KIND_REG_WR, addr, data);
        @(negedge clk);    // Strobe, then register update
        if (addr == REG_ADDR_LO) base[31:0] = data;
        if (addr == REG_ADDR_HI) base[39:32] = data[7:0];
        if (addr == REG_CTRL && data[0]) frame_n = 0;
        if (addr == REG_BPMID && bpmid_o !== data[9:0]) begin
            $display("[ERROR] %s: expected %h, actual %h", name, data[9:0], bpmid_o);
            test_errs++;
        end
        if (addr == REG_TF_LEN && timeframe_length_o !== data[15:0]) begin
            $display("[ERROR] %s: expected %h, actual %h", name, data[15:0], timeframe_length_o);
            test_errs++;
        end
    endtask

    task automatic read_reg(input string name, input ep_reg_e addr, input logic [31:0] exp);
        ep_hdr_t     h;
        logic [65:0] want;
        logic [65:0] got;
        tag = tag + 8'd1;
        send_req(KIND_REG_RD, addr, 32'd0);
        if (rx_ready_o !== 1'b0) begin
            $display("[ERROR] %s rx_ready_o after request: expected 0, actual %b",
                     name, rx_ready_o);
            test_errs++;
        end
        while (beats_q.size() == 0) @(negedge clk);
        if (rx_ready_o !== 1'b1) begin
            $display("[ERROR] %s rx_ready_o after completion: expected 1, actual %b",
                     name, rx_ready_o);
            test_errs++;
        end
        h          = '0;
        h.kind     = KIND_CPLD;
        h.tag      = tag;
        h.len      = 10'd1;
        h.reg_addr = addr;
        want       = {2'b11, h, exp};
        got        = beats_q.pop_front();
        if (got !== want) begin
            $display("[ERROR] %s: expected %h, actual %h", name, want, got);
            test_errs++;
        end
    endtask

    task automatic run_frame(input string name, input int pulses, input int beats);
        ep_hdr_t     h;
        logic [65:0] want;
        logic [65:0] got;
        logic [39:0] addr;
        for (int p = 0; p < pulses; p++) begin
            timeframe_end_rise_i = 1'b1;
            @(negedge clk);
            timeframe_end_rise_i = 1'b0;
            @(negedge clk);
        end
        if (beats == 0) begin
            repeat (40) @(negedge clk);
            if (beats_q.size() != 0) begin
                $display("%s: a packet went out although no frame was due", name);
                test_errs++;
                beats_q.delete();
            end
        end else begin
            while (beats_q.size() < beats + 1) @(negedge clk);
            addr      = base + 40'(frame_n) * 40'(beats) * 40'd8;
            h         = '0;
            h.kind    = KIND_DMA_WR;
            h.len     = beats[9:0];
            h.addr_hi = addr[39:32];
            want      = {2'b10, h, addr[31:0]};
            got       = beats_q.pop_front();
            if (got !== want) begin
                $display("[ERROR] %s header: expected %h, actual %h", name, want, got);
                test_errs++;
            end
            for (int k = 0; k < beats; k++) begin
                want = {1'b0, k == beats - 1, xy_mem[k]};
                got  = beats_q.pop_front();
                if (got !== want) begin
                    $display("[ERROR] %s beat %0d: expected %h, actual %h", name, k, want, got);
                    test_errs++;
                end
            end
            frame_n++;
        end
    endtask

    initial begin
        void'($urandom(32'h7920));
        rst_n                 = 1'b0;
        rx_data_i             = '0;
        rx_sof_i              = 1'b0;
        rx_eof_i              = 1'b0;
        rx_valid_i            = 1'b0;
        fofb_rxlink_up_i      = 1'b0;
        fofb_rxlink_partner_i = '0;
        timeframe_end_rise_i  = 1'b0;
        base                  = '0;
        frame_n               = 0;
        tag                   = 8'ha0;
        for (int i = 0; i < 2**XY_ADDR_W; i++) xy_mem[i] = {$urandom, $urandom};

        for (int r = 0; r < 8; r++) add_step($sformatf("rd_reset_%0d", r), OP_RD,
                                             ep_reg_e'(r), 0, 0);
        add_step("wr_addr_lo", OP_WR, REG_ADDR_LO, 32'h1234_5678, 0);
        add_step("wr_addr_hi", OP_WR, REG_ADDR_HI, 32'h0000_00ab, 0);
        add_step("wr_frame_len", OP_WR, REG_FRAME_LEN, 32'd12, 0);
        add_step("wr_bpmid", OP_WR, REG_BPMID, 32'h0000_0155, 0);
        add_step("wr_tf_len", OP_WR, REG_TF_LEN, 32'h0000_beef, 0);
        add_step("rd_addr_lo", OP_RD, REG_ADDR_LO, 0, 32'h1234_5678);
        add_step("rd_addr_hi", OP_RD, REG_ADDR_HI, 0, 32'h0000_00ab);
        add_step("rd_frame_len", OP_RD, REG_FRAME_LEN, 0, 32'd12);
        add_step("rd_bpmid", OP_RD, REG_BPMID, 0, 32'h0000_0155);
        add_step("rd_tf_len", OP_RD, REG_TF_LEN, 0, 32'h0000_beef);
        add_step("link_set", OP_LINK, REG_LINK, 32'h0000_06a5, 0);
        add_step("wr_link", OP_WR, REG_LINK, 32'd0, 0);
        add_step("rd_link", OP_RD, REG_LINK, 0, 32'h0000_06a5);
        add_step("trig_disabled", OP_TRIG, REG_CTRL, 1, 0);
        add_step("wr_ctrl_en", OP_WR, REG_CTRL, 32'd1, 0);
        add_step("frame_0", OP_TRIG, REG_CTRL, 1, 12);
        add_step("frame_1", OP_TRIG, REG_CTRL, 1, 12);
        add_step("frame_2_overrun", OP_TRIG, REG_CTRL, 2, 12);
        add_step("rd_status", OP_RD, REG_STATUS, 0, 32'h0001_0003);
        add_step("wr_ctrl_restart", OP_WR, REG_CTRL, 32'd1, 0);
        add_step("rd_status_restart", OP_RD, REG_STATUS, 0, 32'd0);
        add_step("frame_after_restart", OP_TRIG, REG_CTRL, 1, 12);
        add_step("wr_ctrl_off", OP_WR, REG_CTRL, 32'd0, 0);
        add_step("trig_off", OP_TRIG, REG_CTRL, 1, 0);
        add_step("rd_status_end", OP_RD, REG_STATUS, 0, 32'd1);

        limit = 4;
        foreach (steps[i]) limit += 50 + (steps[i].op == OP_TRIG ? 4 * steps[i].exp : 0);

        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        foreach (steps[i]) begin
            test_errs = 0;
            @(negedge clk);
            case (steps[i].op)
                OP_WR:   write_reg(names[i], steps[i].addr, steps[i].data);
                OP_RD:   read_reg(names[i], steps[i].addr, steps[i].exp);
                OP_TRIG: run_frame(names[i], steps[i].data, steps[i].exp);
                default: begin
                    fofb_rxlink_up_i      = steps[i].data[10];
                    fofb_rxlink_partner_i = steps[i].data[9:0];
                end
            endcase
            if (test_errs == 0) begin
                n_pass++;
                $display("PASS %s", names[i]);
            end else begin
                n_fail++;
                $display("FAIL %s", names[i]);
            end
        end
        $display("Tests run: %0d, passed: %0d, failed: %0d, assertion failures: %0d",
                 steps.size(), n_pass, n_fail, ep_top_i.sva_i.fail_cnt);
        if (n_fail == 0 && ep_top_i.sva_i.fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
ep_pkg.sv
ep_rx_engine.sv
ep_reg_file.sv
ep_wdma_fsm.sv
ep_tx_engine.sv
ep_top.sv
ep_top_sva.sv
tb_ep_top.sv
